// ==== bench/tb_multi_prec_mac.sv ====
`timescale 1ns/100ps
`include "mac_config.svh"

module tb_multi_prec_mac;

  localparam int HALF_PERIOD = 50;
  localparam int DRIVE_DELAY = 10;
  localparam int SAMPLE_DELAY = 5;
  localparam int RESET_CYCLES = 16;
  localparam int RANDOM_PER_MODE = 300;
  localparam int RANDOM_PER_FALLBACK = 20;
  localparam int MIXED_CYCLES = 100;
  // 16 reset + 1500 named + 220 fallback + 64 extreme + 100 mixed, plus margin
  localparam int TIMEOUT_CYCLES = 2500;
  localparam int OUT_W = `MAC_MUL1_W + `MAC_MUL2_W + 2 * `MAC_MUL34_W;

  logic clk;
  logic reset;
  logic [`MAC_DATA_W-1:0] d;
  logic [`MAC_DATA_W-1:0] w1;
  logic [`MAC_DATA_W-1:0] w2;
  logic [`MAC_DATA_W-1:0] w3;
  logic [`MAC_DATA_W-1:0] w4;
  logic [1:0] convtype_d;
  logic [1:0] convtype_w;
  logic [`MAC_MUL1_W-1:0] mul1;
  logic [`MAC_MUL2_W-1:0] mul2;
  logic [`MAC_MUL34_W-1:0] mul3;
  logic [`MAC_MUL34_W-1:0] mul4;

  int errors = 0;
  int cycles = 0;

  multi_prec_mac dut0 (
    .clk        (clk),
    .reset      (reset),
    .d          (d),
    .w1         (w1),
    .w2         (w2),
    .w3         (w3),
    .w4         (w4),
    .convtype_d (convtype_d),
    .convtype_w (convtype_w),
    .mul1       (mul1),
    .mul2       (mul2),
    .mul3       (mul3),
    .mul4       (mul4)
  );

  initial clk = 1'b0;

  // 100 ns period
  always #HALF_PERIOD clk = ~clk;

  // element widths for a code pair
  // only five pairs are named, all the rest run as 2x2
  function automatic void decode_pair(input logic [1:0] cd, input logic [1:0] cw,
                                      output int dbits, output int wbits);
    dbits = 2;
    wbits = 2;
    if (cd == 2'b11 && cw != 2'b00)
    begin
      dbits = 8;
      wbits = (cw == 2'b11) ? 8 : (cw == 2'b10) ? 4 : 2;
    end
    else if (cd == 2'b10 && (cw == 2'b10 || cw == 2'b01))
    begin
      dbits = 4;
      wbits = (cw == 2'b10) ? 4 : 2;
    end
  endfunction

  // sum of the signed weight elements of one word
  function automatic int weight_sum(input logic [7:0] w, input int wbits);
    int total;
    total = 0;
    case (wbits)
      8: total = $signed(w);
      4: total = $signed(w[3:0]) + $signed(w[7:4]);
      default:
      begin
        for (int k = 0; k < 4; k++)
        begin
          total += $signed(w[2*k +: 2]);
        end
      end
    endcase
    return total;
  endfunction

  // expected outputs packed as {mul1, mul2, mul3, mul4}
  // lane i = data element i times the weight sum of word i+1
  function automatic logic [OUT_W-1:0] expected_outputs(
    input logic [7:0] dv,
    input logic [7:0] a,
    input logic [7:0] b,
    input logic [7:0] c,
    input logic [7:0] e,
    input logic [1:0] cd,
    input logic [1:0] cw
  );
    int dbits;
    int wbits;
    int elem;
    int lanes [4];
    logic [7:0] words [4];
    logic [`MAC_MUL1_W-1:0] m1;
    logic [`MAC_MUL2_W-1:0] m2;
    logic [`MAC_MUL34_W-1:0] m3;
    logic [`MAC_MUL34_W-1:0] m4;
    words = '{a, b, c, e};
    decode_pair(cd, cw, dbits, wbits);
    for (int i = 0; i < 4; i++)
    begin
      lanes[i] = 0;
    end
    for (int i = 0; i < 8 / dbits; i++)
    begin
      elem = (int'(dv) >> (i * dbits)) & ((1 << dbits) - 1);
      lanes[i] = elem * weight_sum(words[i], wbits);
    end
    // lane 0 sign-extended on mul1, idle outputs zero
    m1 = `MAC_MUL1_W'(lanes[0]);
    m2 = (dbits < 8) ? `MAC_MUL2_W'(lanes[1]) : '0;
    m3 = (dbits == 2) ? `MAC_MUL34_W'(lanes[2]) : '0;
    m4 = (dbits == 2) ? `MAC_MUL34_W'(lanes[3]) : '0;
    return {m1, m2, m3, m4};
  endfunction

  // one compare, fatal at the first mismatch
  task automatic check_value(input string name, input logic [`MAC_MUL1_W-1:0] got,
                             input logic [`MAC_MUL1_W-1:0] exp);
    if (got !== exp)
    begin
      errors++;
      $display("FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
      $display("TEST RESULT: FAIL");
      $fatal(1, "output mismatch");
    end
  endtask

  // new operand set shortly after the rising edge
  task automatic drive_operands(input logic [7:0] dv, input logic [7:0] a,
                                input logic [7:0] b, input logic [7:0] c,
                                input logic [7:0] e, input logic [1:0] cd,
                                input logic [1:0] cw);
    @(posedge clk);
    #DRIVE_DELAY;
    d = dv;
    w1 = a;
    w2 = b;
    w3 = c;
    w4 = e;
    convtype_d = cd;
    convtype_w = cw;
  endtask

  task automatic drive_random(input logic [1:0] cd, input logic [1:0] cw);
    drive_operands(8'($urandom()), 8'($urandom()), 8'($urandom()),
                   8'($urandom()), 8'($urandom()), cd, cw);
  endtask

  // inputs at edge n decide the outputs read just after edge n
  initial
  begin : compare_outputs
    logic [OUT_W-1:0] exp;
    forever
    begin
      @(posedge clk);
      if (reset)
      begin
        exp = '0;
      end
      else
      begin
        exp = expected_outputs(d, w1, w2, w3, w4, convtype_d, convtype_w);
      end
      #SAMPLE_DELAY;
      check_value("mul1", mul1, exp[OUT_W-1 -: `MAC_MUL1_W]);
      check_value("mul2", mul2, exp[2*`MAC_MUL34_W +: `MAC_MUL2_W]);
      check_value("mul3", mul3, exp[`MAC_MUL34_W +: `MAC_MUL34_W]);
      check_value("mul4", mul4, exp[`MAC_MUL34_W-1:0]);
    end
  end

  // hard stop on a stuck run
  always @(posedge clk)
  begin
    cycles = cycles + 1;
    if (cycles >= TIMEOUT_CYCLES)
    begin
      $display("timeout: run still going after %0d clock cycles", cycles);
      $display("TEST RESULT: FAIL");
      $fatal(1, "simulation stopped by cycle limit");
    end
  end

  initial
  begin : stimulus
    logic [1:0] named_d [5];
    logic [1:0] named_w [5];
    int dbits;
    int wbits;
    named_d = '{2'b11, 2'b11, 2'b11, 2'b10, 2'b10};
    named_w = '{2'b11, 2'b10, 2'b01, 2'b10, 2'b01};
    void'($urandom(16));
    reset = 1'b1;
    d = '0;
    w1 = '0;
    w2 = '0;
    w3 = '0;
    w4 = '0;
    convtype_d = 2'b00;
    convtype_w = 2'b00;

    // busy operands while in reset, outputs must stay zero
    repeat (RESET_CYCLES - 1)
    begin
      drive_random(2'b11, 2'b11);
    end
    // release with zero data, first edge after reset reads zero
    drive_operands(8'h00, 8'hff, 8'h80, 8'h7f, 8'haa, 2'b11, 2'b11);
    reset = 1'b0;

    // five named modes
    for (int m = 0; m < 5; m++)
    begin
      repeat (RANDOM_PER_MODE)
      begin
        drive_random(named_d[m], named_w[m]);
      end
    end

    // 2x2 pair and every fallback pair, code 00 too
    for (int cd = 0; cd < 4; cd++)
    begin
      for (int cw = 0; cw < 4; cw++)
      begin
        decode_pair(2'(cd), 2'(cw), dbits, wbits);
        if (dbits == 2)
        begin
          repeat (RANDOM_PER_FALLBACK)
          begin
            drive_random(2'(cd), 2'(cw));
          end
        end
      end
    end

    // extreme operands on all sixteen code pairs
    for (int cd = 0; cd < 4; cd++)
    begin
      for (int cw = 0; cw < 4; cw++)
      begin
        drive_operands(8'hff, 8'h80, 8'h80, 8'h80, 8'h80, 2'(cd), 2'(cw));
        drive_operands(8'hff, 8'haa, 8'haa, 8'haa, 8'haa, 2'(cd), 2'(cw));
        drive_operands(8'hff, 8'h7f, 8'h7f, 8'h7f, 8'h7f, 2'(cd), 2'(cw));
        drive_operands(8'h00, 8'($urandom()), 8'($urandom()), 8'($urandom()),
                       8'($urandom()), 2'(cd), 2'(cw));
      end
    end

    // mode changes on every cycle
    repeat (MIXED_CYCLES)
    begin
      drive_random(2'($urandom()), 2'($urandom()));
    end

    // let the last result reach the compare
    repeat (2)
    begin
      @(posedge clk);
    end
    #(DRIVE_DELAY + SAMPLE_DELAY);
    if (errors == 0)
    begin
      $display("TEST RESULT: PASS");
    end
    else
    begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

// ==== list.f ====
+incdir+src
src/mac_pkg.sv
src/slice_grid_if.sv
src/weight_route.sv
src/slice_mult_array.sv
src/lane_reduce.sv
src/multi_prec_mac.sv
bench/tb_multi_prec_mac.sv

// ==== src/lane_reduce.sv ====
`timescale 1ns/100ps
`include "mac_config.svh"

module lane_reduce
  import mac_pkg::*;
(
  input  logic                    clk,
  input  logic                    reset,
  slice_grid_if.reduce            grid,
  output logic [`MAC_MUL1_W-1:0]  mul1,
  output logic [`MAC_MUL2_W-1:0]  mul2,
  output logic [`MAC_MUL34_W-1:0] mul3,
  output logic [`MAC_MUL34_W-1:0] mul4
);

  // every lane is carried at the widest output width
  typedef logic signed [`MAC_MUL1_W-1:0] lane_t;

  prec_e dprec;
  prec_e wprec;

  // sign-extended, shifted products
  lane_t aligned [`MAC_LANES][`MAC_LANES];

  // per-column sum over the four rows
  lane_t col_sum [`MAC_LANES];

  // carry-save pair and resolved value per lane
  lane_t lane_s [`MAC_LANES];
  lane_t lane_c [`MAC_LANES];
  lane_t lane_v [`MAC_LANES];

  // next output values
  logic [`MAC_MUL1_W-1:0]  mul1_d;
  logic [`MAC_MUL2_W-1:0]  mul2_d;
  logic [`MAC_MUL34_W-1:0] mul3_d;
  logic [`MAC_MUL34_W-1:0] mul4_d;

  // slice position within its element
  // 8-bit element has 4 slices, 4-bit has 2, 2-bit has 1
  function automatic int unsigned slice_pos(input prec_e p, input int unsigned i);
    case (p)
      PREC_8: return i;
      PREC_4: return i % 2;
      default: return 0;
    endcase
  endfunction

  // 4:2 compressor built from two 3:2 rows
  function automatic void csa4(
    input  lane_t a0,
    input  lane_t a1,
    input  lane_t a2,
    input  lane_t a3,
    output lane_t s,
    output lane_t cy
  );
    lane_t s1;
    lane_t c1;
    s1 = a0 ^ a1 ^ a2;
    c1 = ((a0 & a1) | (a0 & a2) | (a1 & a2)) << 1;
    s = s1 ^ c1 ^ a3;
    cy = ((s1 & c1) | (s1 & a3) | (c1 & a3)) << 1;
  endfunction

  assign dprec = data_prec(grid.mode);
  assign wprec = weight_prec(grid.mode);

  // shift is twice the data slice position plus twice the weight slice position
  // weight elements of one word all start at shift 0, so they add up
  always_comb
  begin
    lane_t ext;
    int unsigned sh;
    for (int unsigned c = 0; c < `MAC_LANES; c++)
    begin
      for (int unsigned r = 0; r < `MAC_LANES; r++)
      begin
        ext = grid.prod[c][r];
        sh = `MAC_SLICE_W * (slice_pos(dprec, c) + slice_pos(wprec, r));
        aligned[c][r] = ext << sh;
      end
    end
  end

  // rows of one column always belong to the same lane
  always_comb
  begin
    for (int unsigned c = 0; c < `MAC_LANES; c++)
    begin
      col_sum[c] = aligned[c][0] + aligned[c][1] + aligned[c][2] + aligned[c][3];
    end
  end

  // each lane keeps only the columns it owns before compressing
  always_comb
  begin
    lane_t term [`MAC_LANES];
    for (int unsigned l = 0; l < `MAC_LANES; l++)
    begin
      for (int unsigned c = 0; c < `MAC_LANES; c++)
      begin
        term[c] = (col_owner(dprec, c) == l) ? col_sum[c] : '0;
      end
      csa4(term[0], term[1], term[2], term[3], lane_s[l], lane_c[l]);
      // final carry-propagate add
      lane_v[l] = lane_s[l] + lane_c[l];
    end
  end

  // output placement by data precision
  // lane 0 always goes to mul1 and unused outputs are forced to zero
  always_comb
  begin
    mul1_d = lane_v[0];
    mul2_d = '0;
    mul3_d = '0;
    mul4_d = '0;
    if (dprec != PREC_8)
    begin
      mul2_d = lane_v[1][`MAC_MUL2_W-1:0];
    end
    if (dprec == PREC_2)
    begin
      mul3_d = lane_v[2][`MAC_MUL34_W-1:0];
      mul4_d = lane_v[3][`MAC_MUL34_W-1:0];
    end
  end

  // single pipeline stage
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      mul1 <= '0;
      mul2 <= '0;
      mul3 <= '0;
      mul4 <= '0;
    end
    else
    begin
      mul1 <= mul1_d;
      mul2 <= mul2_d;
      mul3 <= mul3_d;
      mul4 <= mul4_d;
    end
  end

  // products loaded into the register must be known once out of reset
  prod_known: assert property (@(posedge clk) disable iff (reset)
    !$isunknown(grid.prod))
    else $error("lane_reduce: unknown slice product at the output register");

endmodule

// ==== src/mac_config.svh ====
`ifndef MAC_CONFIG_SVH
`define MAC_CONFIG_SVH

// data word and each weight word
`define MAC_DATA_W 8

// slice width of one grid multiplier
`define MAC_SLICE_W 2

// grid columns, grid rows and output lanes
`define MAC_LANES 4

// signed product of one slice pair
// range -6 to 9 needs 5 bits
`define MAC_PROD_W 5

// output widths
// mul1 holds the widest lane, 8-bit data times 8-bit weight
`define MAC_MUL1_W 19

// mul2 holds lane 1 of 4-bit or 2-bit data
`define MAC_MUL2_W 9

// mul3 and mul4 only carry 2-bit data lanes
`define MAC_MUL34_W 7

`endif

// ==== src/mac_pkg.sv ====
`include "mac_config.svh"

package mac_pkg;

  // precision code, same encoding for data and weights
  // code 00 has no name and decodes as 2-bit
  typedef enum logic [1:0] {
    PREC_2 = 2'b01,
    PREC_4 = 2'b10,
    PREC_8 = 2'b11
  } prec_e;

  // decoded operating mode, data by weight
  typedef enum logic [2:0] {
    M8X8,
    M8X4,
    M8X2,
    M4X4,
    M4X2,
    M2X2
  } mode_e;

  typedef logic [`MAC_SLICE_W-1:0] slice_t;
  typedef logic signed [2*`MAC_SLICE_W-1:0] nibble_t;
  typedef logic signed [`MAC_PROD_W-1:0] prod_t;

  // one weight word seen as a byte, two nibbles or four slices
  typedef union packed {
    logic signed [`MAC_DATA_W-1:0] full;
    nibble_t [1:0] nibble;
    slice_t [`MAC_LANES-1:0] slices;
  } weight_word_u;

  // grid arrays, first index column, second index row
  typedef slice_t [`MAC_LANES-1:0][`MAC_LANES-1:0] slice_grid_t;
  typedef prod_t [`MAC_LANES-1:0][`MAC_LANES-1:0] prod_grid_t;

  // data precision implied by a mode
  function automatic prec_e data_prec(input mode_e mode);
    case (mode)
      M8X8, M8X4, M8X2: return PREC_8;
      M4X4, M4X2: return PREC_4;
      default: return PREC_2;
    endcase
  endfunction

  // weight precision implied by a mode
  function automatic prec_e weight_prec(input mode_e mode);
    case (mode)
      M8X8: return PREC_8;
      M8X4, M4X4: return PREC_4;
      default: return PREC_2;
    endcase
  endfunction

  // data element, and so lane, that owns grid column c
  function automatic int unsigned col_owner(input prec_e dprec, input int unsigned c);
    case (dprec)
      PREC_8: return 0;
      PREC_4: return c / 2;
      default: return c;
    endcase
  endfunction

endpackage

// ==== src/multi_prec_mac.sv ====
`timescale 1ns/100ps
`include "mac_config.svh"

module multi_prec_mac
  import mac_pkg::*;
(
  input  logic                    clk,
  input  logic                    reset,
  input  logic [`MAC_DATA_W-1:0]  d,
  input  logic [`MAC_DATA_W-1:0]  w1,
  input  logic [`MAC_DATA_W-1:0]  w2,
  input  logic [`MAC_DATA_W-1:0]  w3,
  input  logic [`MAC_DATA_W-1:0]  w4,
  input  logic [1:0]              convtype_d,
  input  logic [1:0]              convtype_w,
  output logic [`MAC_MUL1_W-1:0]  mul1,
  output logic [`MAC_MUL2_W-1:0]  mul2,
  output logic [`MAC_MUL34_W-1:0] mul3,
  output logic [`MAC_MUL34_W-1:0] mul4
);

  // routed grid and products, all combinational
  slice_grid_if grid_if ();

  // mode decode and operand routing
  weight_route u_weight_route (
    .d          (d),
    .w1         (w1),
    .w2         (w2),
    .w3         (w3),
    .w4         (w4),
    .convtype_d (prec_e'(convtype_d)),
    .convtype_w (prec_e'(convtype_w)),
    .grid       (grid_if.route)
  );

  // sixteen 2x2 slice multipliers
  slice_mult_array u_slice_mult_array (
    .grid (grid_if.mult)
  );

  // align, reduce, place and register
  lane_reduce u_lane_reduce (
    .clk   (clk),
    .reset (reset),
    .grid  (grid_if.reduce),
    .mul1  (mul1),
    .mul2  (mul2),
    .mul3  (mul3),
    .mul4  (mul4)
  );

endmodule

// ==== src/slice_grid_if.sv ====
`timescale 1ns/100ps
`include "mac_config.svh"

interface slice_grid_if
  import mac_pkg::*;
();

  // decoded mode, drives alignment and output placement
  mode_e mode;

  // one unsigned data slice per column
  slice_t [`MAC_LANES-1:0] dslice;

  // routed weight slices, [column][row]
  slice_grid_t wslice;

  // flag per cell at bit column*4+row
  // set on the top slice of each weight element
  logic [`MAC_LANES*`MAC_LANES-1:0] wsign;

  // signed slice products, [column][row]
  prod_grid_t prod;

  // decoder and router side
  modport route (
    output mode,
    output dslice,
    output wslice,
    output wsign
  );

  // multiplier grid
  modport mult (
    input  dslice,
    input  wslice,
    input  wsign,
    output prod
  );

  // alignment, reduction and output register
  modport reduce (
    input mode,
    input prod
  );

endinterface

// ==== src/slice_mult_array.sv ====
`timescale 1ns/100ps
`include "mac_config.svh"

module slice_mult_array
  import mac_pkg::*;
(
  slice_grid_if.mult grid
);

  // one 2x2 slice product
  // weight slice signed only where flagged and data slice always unsigned
  function automatic prod_t slice_mul(
    input slice_t w,
    input logic   is_signed,
    input slice_t dv
  );
    logic signed [`MAC_SLICE_W:0] wx;
    logic signed [`MAC_SLICE_W:0] dx;
    logic signed [2*`MAC_SLICE_W+1:0] p;
    // extend by one sign or zero bit
    wx = is_signed ? {w[`MAC_SLICE_W-1], w} : {1'b0, w};
    dx = {1'b0, dv};
    p = wx * dx;
    // -6..9 always fits the product width
    return p[`MAC_PROD_W-1:0];
  endfunction

  // all sixteen cells in parallel
  // column c shares data slice c
  always_comb
  begin
    for (int unsigned c = 0; c < `MAC_LANES; c++)
    begin
      for (int unsigned r = 0; r < `MAC_LANES; r++)
      begin
        grid.prod[c][r] = slice_mul(grid.wslice[c][r],
                                    grid.wsign[c*`MAC_LANES+r],
                                    grid.dslice[c]);
      end
    end
  end

endmodule

// ==== src/weight_route.sv ====
`timescale 1ns/100ps
`include "mac_config.svh"

module weight_route
  import mac_pkg::*;
(
  input  logic [`MAC_DATA_W-1:0] d,
  input  weight_word_u           w1,
  input  weight_word_u           w2,
  input  weight_word_u           w3,
  input  weight_word_u           w4,
  input  prec_e                  convtype_d,
  input  prec_e                  convtype_w,
  slice_grid_if.route            grid
);

  mode_e mode;
  prec_e dprec;
  prec_e wprec;

  // weight words indexed by data element
  weight_word_u words [`MAC_LANES];

  // word routed onto each column
  weight_word_u col_word [`MAC_LANES];

  // per-row signed flag shared by every column
  logic [`MAC_LANES-1:0] row_sign;

  // code pair decode
  // only the five named pairs have their own mode
  always_comb
  begin
    case ({convtype_d, convtype_w})
      {PREC_8, PREC_8}: mode = M8X8;
      {PREC_8, PREC_4}: mode = M8X4;
      {PREC_8, PREC_2}: mode = M8X2;
      {PREC_4, PREC_4}: mode = M4X4;
      {PREC_4, PREC_2}: mode = M4X2;
      // 2x2 pair, code 00 and the unnamed pairs
      default: mode = M2X2;
    endcase
  end

  assign dprec = data_prec(mode);
  assign wprec = weight_prec(mode);

  assign words[0] = w1;
  assign words[1] = w2;
  assign words[2] = w3;
  assign words[3] = w4;

  // column c takes the word of the element owning data slice c
  // w1 everywhere for 8-bit data
  // w1 on columns 0 and 1 and w2 on 2 and 3 for 4-bit data
  // one word per column for 2-bit data
  always_comb
  begin
    for (int unsigned c = 0; c < `MAC_LANES; c++)
    begin
      col_word[c] = words[col_owner(dprec, c)];
      grid.dslice[c] = d[c*`MAC_SLICE_W +: `MAC_SLICE_W];
      for (int unsigned r = 0; r < `MAC_LANES; r++)
      begin
        grid.wslice[c][r] = col_word[c].slices[r];
      end
    end
  end

  // top slice of each weight element carries the sign
  always_comb
  begin
    case (wprec)
      PREC_8: row_sign = 4'b1000;
      PREC_4: row_sign = 4'b1010;
      default: row_sign = 4'b1111;
    endcase
  end

  // column-major flags at bit index column*4+row
  assign grid.wsign = {`MAC_LANES{row_sign}};
  assign grid.mode = mode;

  // an unknown code pair would decode silently as 2x2
  always_comb
  begin
    assert final (!$isunknown({convtype_d, convtype_w}))
      else $error("weight_route: unknown precision code %b/%b",
                  convtype_d, convtype_w);
  end

endmodule
